// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_sprite_unit
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: rtl/oam_ram.sv
`timescale 1ns/1ns

module oam_ram (
    input  logic                clk,
    input  logic                wr,
    input  ppu_pkg::oam_addr_t  wr_addr,
    input  ppu_pkg::oam_byte_t  wr_data,
    input  ppu_pkg::oam_addr_t  rd_addr,
    output ppu_pkg::oam_byte_t  rd_data
);

    // 64 sprites, four bytes each
    ppu_pkg::oam_byte_t mem [256];

    // cpu side, not tied to the ppu enable
    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // evaluator reads the byte for the current dot
    assign rd_data = mem[rd_addr];

endmodule

// File: rtl/ppu_pkg.sv
package ppu_pkg;

    // scanline and dot counters
    typedef logic [8:0] row_t;
    typedef logic [8:0] col_t;

    // primary object memory
    typedef logic [7:0] oam_addr_t;
    typedef logic [7:0] oam_byte_t;

    // one sprite as stored in object memory, y byte first
    typedef struct packed {
        oam_byte_t y_pos;
        oam_byte_t tile_idx;
        oam_byte_t attribute;
        oam_byte_t x_pos;
    } sprite_t;

    // secondary object memory
    typedef logic [2:0] sec_idx_t;
    typedef logic [3:0] sec_count_t;

    // horizontal phase within a line
    typedef enum logic [2:0] {
        IDLE_CYC,
        SL_PRE_CYC,
        SP_PRE_CYC,
        TL_PRE_CYC,
        GARB_CYC
    } hs_state_t;

    localparam row_t LAST_ROW       = 9'd261;
    localparam col_t LAST_COL       = 9'd340;
    localparam row_t VISIBLE_ROWS   = 9'd240;
    localparam row_t PRE_RENDER_ROW = 9'd261;
    localparam row_t SPRITE_HEIGHT  = 9'd8;

endpackage

// File: rtl/scan_timing.sv
`timescale 1ns/1ns

module scan_timing (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              clk_en,
    output ppu_pkg::row_t     row,
    output ppu_pkg::col_t     col,
    output ppu_pkg::hs_state_t hs_state
);

    logic rendering;

    // dot and line counters at the ppu rate
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row <= '0;
            col <= '0;
        end else if (clk_en) begin
            if (col == ppu_pkg::LAST_COL) begin
                col <= '0;
                if (row == ppu_pkg::LAST_ROW) begin
                    row <= '0;
                end else begin
                    row <= row + 1'b1;
                end
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // visible lines plus the pre-render line
    assign rendering = (row < ppu_pkg::VISIBLE_ROWS) || (row == ppu_pkg::PRE_RENDER_ROW);

    always_comb begin
        if (!rendering) begin
            hs_state = ppu_pkg::IDLE_CYC;
        end else if (col < 9'd256) begin
            hs_state = ppu_pkg::SL_PRE_CYC;
        end else if (col < 9'd320) begin
            hs_state = ppu_pkg::SP_PRE_CYC;
        end else if (col < 9'd336) begin
            hs_state = ppu_pkg::TL_PRE_CYC;
        end else begin
            hs_state = ppu_pkg::GARB_CYC;
        end
    end

    // counters stay inside the frame
    a_col_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        (col <= ppu_pkg::LAST_COL) && (row <= ppu_pkg::LAST_ROW)
    );

endmodule

// File: rtl/sec_oam.sv
`timescale 1ns/1ns

module sec_oam #(
    parameter int SEC_ENTRIES = 8
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 clk_en,
    input  logic                 clr,
    input  logic                 wr,
    input  ppu_pkg::sprite_t     wr_data,
    input  ppu_pkg::sec_idx_t    rd_idx,
    output ppu_pkg::sprite_t     rd_data,
    output ppu_pkg::sec_count_t  count,
    output logic                 overflow
);

    ppu_pkg::sprite_t entries [SEC_ENTRIES];
    logic             has_room;

    assign has_room = count < ppu_pkg::sec_count_t'(SEC_ENTRIES);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < SEC_ENTRIES; i++) begin
                entries[i] <= '1;
            end
            count    <= '0;
            overflow <= 1'b0;
        end else if (clk_en) begin
            if (clr) begin
                // empty slots read back as all ones
                for (int i = 0; i < SEC_ENTRIES; i++) begin
                    entries[i] <= '1;
                end
                count    <= '0;
                overflow <= 1'b0;
            end else if (wr) begin
                if (has_room) begin
                    entries[ppu_pkg::sec_idx_t'(count)] <= wr_data;
                    count <= count + 1'b1;
                end else begin
                    // ninth match and later are dropped
                    overflow <= 1'b1;
                end
            end
        end
    end

    assign rd_data = entries[rd_idx];

    // clear comes at dot 340, appends only during evaluation
    a_clr_wr_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        clk_en |-> !(clr && wr)
    );

endmodule

// File: rtl/sp_eval.sv
`timescale 1ns/1ns

module sp_eval (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                clk_en,
    input  ppu_pkg::row_t       row,
    input  ppu_pkg::col_t       col,
    input  ppu_pkg::hs_state_t  hs_state,
    output ppu_pkg::oam_addr_t  oam_addr,
    input  ppu_pkg::oam_byte_t  oam_data,
    output logic                sec_clr,
    output logic                sec_wr,
    output ppu_pkg::sprite_t    sec_wr_data
);

    ppu_pkg::row_t    target_line;
    ppu_pkg::row_t    y_diff;
    logic             in_range;
    logic             evaluating;
    logic             hit;
    ppu_pkg::sprite_t stage;

    // sprite col/4, byte col mod 4
    assign oam_addr = col[7:0];

    assign evaluating = (hs_state == ppu_pkg::SL_PRE_CYC);

    // evaluation looks one line ahead, pre-render feeds line 0
    assign target_line = (row == ppu_pkg::PRE_RENDER_ROW) ? '0 : row + 1'b1;

    // negative differences wrap high and fail the compare
    assign y_diff   = target_line - {1'b0, oam_data};
    assign in_range = y_diff < ppu_pkg::SPRITE_HEIGHT;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit <= 1'b0;
        end else if (clk_en) begin
            if (!evaluating) begin
                hit <= 1'b0;
            end else if (col[1:0] == 2'd0) begin
                hit <= in_range;
            end
        end
    end

    // staging record
    always_ff @(posedge clk) begin
        if (clk_en && evaluating) begin
            unique case (col[1:0])
                2'd0: stage.y_pos <= oam_data;
                2'd1: if (hit) stage.tile_idx  <= oam_data;
                2'd2: if (hit) stage.attribute <= oam_data;
                2'd3: if (hit) stage.x_pos     <= oam_data;
            endcase
        end
    end

    // x byte goes straight through so the append lands on byte 3
    always_comb begin
        sec_wr_data       = stage;
        sec_wr_data.x_pos = oam_data;
    end

    assign sec_wr = evaluating && (col[1:0] == 2'd3) && hit;

    // end-of-line clear on rendering rows
    assign sec_clr = (hs_state == ppu_pkg::GARB_CYC) && (col == ppu_pkg::LAST_COL);

    // appends only on the last byte of a sprite slot
    a_wr_slot: assert property (
        @(posedge clk) disable iff (!rst_n)
        sec_wr |-> (hs_state == ppu_pkg::SL_PRE_CYC && col[1:0] == 2'd3)
    );

endmodule

// File: rtl/sprite_unit.sv
`timescale 1ns/1ns

module sprite_unit #(
    parameter int SEC_ENTRIES = 8
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 clk_en,
    input  logic                 oam_wr,
    input  ppu_pkg::oam_addr_t   oam_wr_addr,
    input  ppu_pkg::oam_byte_t   oam_wr_data,
    input  ppu_pkg::sec_idx_t    sec_rd_idx,
    output ppu_pkg::sprite_t     sec_rd_data,
    output ppu_pkg::sec_count_t  sprite_count,
    output logic                 sprite_overflow,
    output ppu_pkg::row_t        row,
    output ppu_pkg::col_t        col
);

    ppu_pkg::hs_state_t hs_state;
    ppu_pkg::oam_addr_t oam_addr;
    ppu_pkg::oam_byte_t oam_data;
    logic               sec_clr;
    logic               sec_wr;
    ppu_pkg::sprite_t   sec_wr_data;

    scan_timing u_timing (
        .clk      (clk),
        .rst_n    (rst_n),
        .clk_en   (clk_en),
        .row      (row),
        .col      (col),
        .hs_state (hs_state)
    );

    oam_ram u_oam (
        .clk     (clk),
        .wr      (oam_wr),
        .wr_addr (oam_wr_addr),
        .wr_data (oam_wr_data),
        .rd_addr (oam_addr),
        .rd_data (oam_data)
    );

    sp_eval u_eval (
        .clk         (clk),
        .rst_n       (rst_n),
        .clk_en      (clk_en),
        .row         (row),
        .col         (col),
        .hs_state    (hs_state),
        .oam_addr    (oam_addr),
        .oam_data    (oam_data),
        .sec_clr     (sec_clr),
        .sec_wr      (sec_wr),
        .sec_wr_data (sec_wr_data)
    );

    sec_oam #(
        .SEC_ENTRIES (SEC_ENTRIES)
    ) u_sec_oam (
        .clk      (clk),
        .rst_n    (rst_n),
        .clk_en   (clk_en),
        .clr      (sec_clr),
        .wr       (sec_wr),
        .wr_data  (sec_wr_data),
        .rd_idx   (sec_rd_idx),
        .rd_data  (sec_rd_data),
        .count    (sprite_count),
        .overflow (sprite_overflow)
    );

endmodule

// File: sim.f
rtl/ppu_pkg.sv
rtl/scan_timing.sv
rtl/oam_ram.sv
rtl/sec_oam.sv
rtl/sp_eval.sv
rtl/sprite_unit.sv
sim/tb_sprite_unit.sv

// File: sim/sprite_testdata.txt
# w addr byte (hex) writes primary memory; r row count overflow (decimal) runs to dot 256
# e idx y tile attr x (hex) is the expected secondary entry after the last r line
w 14 14
w 15 21
w 16 02
w 17 40
w 30 0d
w 78 15
w a0 0c
w c8 11
w 50 5d
w 54 5e
w 58 5f
w 5c 60
w 60 61
w 64 62
w 68 63
w 6c 64
w 70 64
w 74 5d
w f0 93
w 00 00
w fc 01
r 19 3 0
e 0 14 21 02 40
e 1 0d ce cd cc
e 2 11 36 35 34
e 3 ff ff ff ff
r 99 8 1
e 0 5d ae ad ac
e 1 5e aa a9 a8
e 2 5f a6 a5 a4
e 3 60 a2 a1 a0
e 4 61 9e 9d 9c
e 5 62 9a 99 98
e 6 63 96 95 94
e 7 64 92 91 90
r 149 1 0
e 0 93 0e 0d 0c
e 1 ff ff ff ff
r 261 1 0
e 0 00 fe fd fc
e 1 ff ff ff ff
r 0 2 0
e 0 00 fe fd fc
e 1 01 02 01 00

// File: sim/tb_sprite_unit.sv
`timescale 1ns/1ns

module tb_sprite_unit;

    // a full frame is 262 * 341 enabled cycles, four clocks each
    localparam int WAIT_LIMIT = 400000;

    logic                clk;
    logic                rst_n;
    logic                clk_en;
    logic                oam_wr;
    ppu_pkg::oam_addr_t  oam_wr_addr;
    ppu_pkg::oam_byte_t  oam_wr_data;
    ppu_pkg::sec_idx_t   sec_rd_idx;
    ppu_pkg::sprite_t    sec_rd_data;
    ppu_pkg::sec_count_t sprite_count;
    logic                sprite_overflow;
    ppu_pkg::row_t       row;
    ppu_pkg::col_t       col;

    int checks;

    sprite_unit #(
        .SEC_ENTRIES (8)
    ) UUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .clk_en          (clk_en),
        .oam_wr          (oam_wr),
        .oam_wr_addr     (oam_wr_addr),
        .oam_wr_data     (oam_wr_data),
        .sec_rd_idx      (sec_rd_idx),
        .sec_rd_data     (sec_rd_data),
        .sprite_count    (sprite_count),
        .sprite_overflow (sprite_overflow),
        .row             (row),
        .col             (col)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic report_mismatch(input string msg);
        abort_run($sformatf("FAILED at %0t ns: %s", $time, msg));
    endtask

    task automatic check_sprite(input ppu_pkg::sec_idx_t idx, input ppu_pkg::sprite_t got,
                                input ppu_pkg::sprite_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("entry %0d reads %h, expected %h", idx, got, exp));
        end else begin
            checks++;
        end
    endtask

    task automatic check_count(input ppu_pkg::sec_count_t got, input ppu_pkg::sec_count_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("sprite count %0d, expected %0d", got, exp));
        end else begin
            checks++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp);
        if (got !== exp) begin
            report_mismatch($sformatf("overflow flag %b, expected %b", got, exp));
        end else begin
            checks++;
        end
    endtask

    task automatic check_pos(input ppu_pkg::row_t exp_row, input ppu_pkg::col_t exp_col);
        if (row !== exp_row || col !== exp_col) begin
            report_mismatch($sformatf("position row %0d col %0d, expected row %0d col %0d",
                                      row, col, exp_row, exp_col));
        end else begin
            checks++;
        end
    endtask

    // y bytes stay at 0xf8 and above, so unwritten sprites never match a line
    function automatic ppu_pkg::oam_byte_t fill_byte(input ppu_pkg::oam_addr_t a);
        ppu_pkg::oam_byte_t b;
        if (a[1:0] == 2'd0) begin
            b = 8'hf8 | {5'd0, a[7:5] ^ a[4:2]};
        end else begin
            b = ~a;
        end
        return b;
    endfunction

    task automatic write_oam(input ppu_pkg::oam_addr_t a, input ppu_pkg::oam_byte_t d);
        oam_wr      = 1'b1;
        oam_wr_addr = a;
        oam_wr_data = d;
        @(posedge clk);
        #1;
        oam_wr = 1'b0;
    endtask

    // one enabled edge in four until evaluation of the row is done
    task automatic run_to_line(input ppu_pkg::row_t target);
        int cycles;
        int phase;
        cycles = 0;
        phase  = 0;
        while (!(row == target && col == 9'd256)) begin
            if (cycles >= WAIT_LIMIT) begin
                abort_run($sformatf("timeout: dot 256 of row %0d was never reached", target));
            end
            clk_en = (phase == 3);
            phase  = (phase + 1) % 4;
            @(posedge clk);
            #1;
            cycles++;
        end
        clk_en = 1'b0;
    endtask

    task automatic read_entry(input ppu_pkg::sec_idx_t idx, input ppu_pkg::sprite_t exp);
        sec_rd_idx = idx;
        @(negedge clk);
        check_sprite(idx, sec_rd_data, exp);
        @(posedge clk);
        #1;
    endtask

    initial begin
        int    fd;
        int    n;
        int    f0;
        int    f1;
        int    f2;
        int    f3;
        int    f4;
        byte   kind;
        string line;
        string rest;

        rst_n       = 1'b0;
        clk_en      = 1'b0;
        oam_wr      = 1'b0;
        oam_wr_addr = '0;
        oam_wr_data = '0;
        sec_rd_idx  = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        check_pos(9'd0, 9'd0);
        check_count(sprite_count, 4'd0);
        check_flag(sprite_overflow, 1'b0);

        for (int i = 0; i < 256; i++) begin
            write_oam(ppu_pkg::oam_addr_t'(i), fill_byte(ppu_pkg::oam_addr_t'(i)));
        end

        // count only the checks that come from the data file
        checks = 0;
        fd = $fopen("sim/sprite_testdata.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open sim/sprite_testdata.txt");
        end
        while ($fgets(line, fd) > 0) begin
            kind = line.getc(0);
            rest = line.substr(1, line.len() - 1);
            if (kind == "w") begin
                n = $sscanf(rest, "%h %h", f0, f1);
                if (n != 2) begin
                    abort_run($sformatf("malformed write line in data file: %s", line));
                end
                write_oam(ppu_pkg::oam_addr_t'(f0), ppu_pkg::oam_byte_t'(f1));
            end else if (kind == "r") begin
                n = $sscanf(rest, "%d %d %d", f0, f1, f2);
                if (n != 3) begin
                    abort_run($sformatf("malformed line check in data file: %s", line));
                end
                run_to_line(ppu_pkg::row_t'(f0));
                check_count(sprite_count, ppu_pkg::sec_count_t'(f1));
                check_flag(sprite_overflow, f2[0]);
            end else if (kind == "e") begin
                n = $sscanf(rest, "%h %h %h %h %h", f0, f1, f2, f3, f4);
                if (n != 5) begin
                    abort_run($sformatf("malformed entry line in data file: %s", line));
                end
                read_entry(ppu_pkg::sec_idx_t'(f0),
                           ppu_pkg::sprite_t'({f1[7:0], f2[7:0], f3[7:0], f4[7:0]}));
            end
        end
        $fclose(fd);

        if (checks == 0) begin
            abort_run("the data file held no checks");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule
